/* testbench/fpu_tests.txt */
# columns: name, opcode (hex), a (hex), b (hex), expected y (hex), expected flags (binary ovf nan invalid)
# opcodes: 0 add, 1 sub, 2 mul, 3 abs, 4 neg, 5 ftoi, 6 itof (b is the integer), 7 unused
add_one_two        0 3f800000 40000000 40400000 000
add_half_quarter   0 3f000000 3e800000 3f400000 000
add_tie_even_down  0 3f800000 33800000 3f800000 000
add_tie_even_up    0 3f800001 33800000 3f800002 000
add_subnormals     0 00000001 00000001 00000002 000
add_sub_to_normal  0 007fffff 00000001 00800000 000
add_overflow       0 7f7fffff 7f7fffff 7f800000 100
add_nan_operand    0 7fc00001 3f800000 7fc00001 000
sub_self           1 3fc00000 3fc00000 00000000 000
sub_negative       1 3f800000 40000000 bf800000 000
sub_inf_inf        1 7f800000 7f800000 ffc00000 000
mul_basic          2 3fc00000 40000000 40400000 000
mul_round          2 3f800001 3f800001 3f800002 000
mul_subnormal_out  2 00800000 3f000000 00400000 000
mul_subnormal_in   2 00000001 4b000000 00800000 000
mul_overflow_neg   2 ff000000 40000000 ff800000 100
mul_inf_zero       2 7f800000 00000000 ffc00000 000
ftoi_two_half      5 40200000 00000000 00000003 000
ftoi_neg_two_half  5 c0200000 00000000 fffffffd 000
ftoi_half          5 3f000000 00000000 00000001 000
ftoi_small         5 3ecccccd 00000000 00000000 000
ftoi_1234_half     5 449a5000 00000000 000004d3 000
ftoi_min_int       5 cf000000 00000000 80000000 000
ftoi_two_pow_31    5 4f000000 00000000 00000000 100
ftoi_huge          5 7f000000 00000000 00000000 100
ftoi_nan           5 7fc00000 00000000 00000000 010
itof_one           6 00000000 00000001 3f800000 000
itof_minus_100     6 00000000 ffffff9c c2c80000 000
itof_tie_even      6 00000000 01000001 4b800000 000
itof_round_up      6 00000000 01000003 4b800002 000
itof_min_int       6 00000000 80000000 cf000000 000
abs_negative       3 c0490fdb 00000000 40490fdb 000
neg_positive       4 3f800000 00000000 bf800000 000
neg_zero           4 00000000 00000000 80000000 000
unused_opcode      7 3f800000 40000000 00000000 001

/* src.f */
+incdir+rtl
rtl/fp_format_pkg.sv
rtl/fpu_op_pkg.sv
rtl/fp_addsub.sv
rtl/fp_mul.sv
rtl/fp_convert.sv
rtl/fpu_delay_line.sv
rtl/fpu_result_select.sv
rtl/fpu_top.sv
testbench/fpu_assert.sv
testbench/fpu_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module fpu_tb -f src.f -o fpu_sim \
	&& ./obj_dir/fpu_sim +verilator+error+limit+100 | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* testbench/fpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpu_config.svh"

module fpu_tb;
	import fp_format_pkg::*;
	import fpu_op_pkg::*;

	localparam int reset_cycles = 16;
	localparam int drain_limit = `FPU_LATENCY + 8;

	logic clk;
	logic rstn;
	fpu_op_t op;
	fp_word_t a, b, y;
	fpu_exc_t exc;

	// test table, one entry per data file line
	string names[$];
	logic [2:0] op_codes[$];
	fp_word_t a_vals[$], b_vals[$], y_vals[$];
	fpu_exc_t exc_vals[$];

	// issued tests still in flight
	int pend_idx[$];
	int pend_due[$];

	int cycle;
	int checks, word_errors, flag_errors, other_errors, assert_fails;

	fpu_top DUT (.clk, .rstn, .op, .a, .b, .y, .exc);

	bind fpu_top fpu_assert u_checks (.clk, .rstn, .op, .y, .exc);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	task automatic check_word(input string name, input fp_word_t expected,
		input fp_word_t actual);
		checks++;
		if (actual !== expected) begin
			word_errors++;
			$display("ERROR %s: y expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_exc(input string name, input fpu_exc_t expected,
		input fpu_exc_t actual);
		checks++;
		if (actual !== expected) begin
			flag_errors++;
			$display("ERROR %s: exc (ovf nan invalid) expected %b, actual %b",
				name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// data file and pipeline bookkeeping
	task automatic load_tests();
		int fd, code, n;
		string line, test_name;
		logic [2:0] op_v, exc_v;
		logic [31:0] a_v, b_v, y_v;
		fd = $fopen("testbench/fpu_tests.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open testbench/fpu_tests.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				// comment lines start with #
				if (code > 0 && line.len() > 1 && line[0] != "#") begin
					n = $sscanf(line, "%s %h %h %h %h %b",
						test_name, op_v, a_v, b_v, y_v, exc_v);
					if (n == 6) begin
						names.push_back(test_name);
						op_codes.push_back(op_v);
						a_vals.push_back(fp_word_t'(a_v));
						b_vals.push_back(fp_word_t'(b_v));
						y_vals.push_back(fp_word_t'(y_v));
						exc_vals.push_back(fpu_exc_t'(exc_v));
					end else begin
						other_errors++;
						$display("malformed line in test file: %s", line);
					end
				end
			end
			$fclose(fd);
			if (names.size() == 0) begin
				other_errors++;
				$display("test file holds no tests");
			end
		end
	endtask

	task automatic issue(input int i);
		op = fpu_op_t'(op_codes[i]);
		a = a_vals[i];
		b = b_vals[i];
		pend_idx.push_back(i);
		pend_due.push_back(cycle + `FPU_LATENCY);	// fixed latency, no handshake
	endtask

	task automatic compare_due();
		int i;
		if (pend_due.size() > 0 && pend_due[0] == cycle) begin
			i = pend_idx.pop_front();
			pend_due.delete(0);
			check_word(names[i], y_vals[i], y);
			check_exc(names[i], exc_vals[i], exc);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	initial begin
		int idx;
		int waited;
		rstn = 1'b0;
		op = OP_MUL;	// busy operands while in reset
		a = 32'h40000000;
		b = 32'h40400000;
		checks = 0;
		word_errors = 0;
		flag_errors = 0;
		other_errors = 0;
		cycle = 0;
		load_tests();

		repeat (reset_cycles) @(posedge clk);
		#1;
		rstn = 1'b1;
		op = OP_ADD;
		a = '0;
		b = '0;

		// y stays cleared until the first issued result
		for (int k = 0; k < `FPU_LATENCY; k++) begin
			@(posedge clk);
			#1;
			check_word("after_reset", '0, y);
			check_exc("after_reset", '0, exc);
		end

		// one test per cycle, then idle until the queue drains
		idx = 0;
		waited = 0;
		while ((idx < names.size() || pend_due.size() > 0) && waited < drain_limit) begin
			compare_due();
			if (idx < names.size()) begin
				issue(idx);
				idx++;
			end else begin
				op = OP_ADD;
				a = '0;
				b = '0;
				waited++;
			end
			@(posedge clk);
			#1;
			cycle++;
		end
		if (pend_due.size() > 0) begin
			other_errors++;
			$display("timeout: %0d results never came out of the pipeline", pend_due.size());
		end

		assert_fails = DUT.u_checks.fail_count;
		$display("checks %0d, errors word %0d flag %0d other %0d assertion %0d",
			checks, word_errors, flag_errors, other_errors, assert_fails);
		if (word_errors + flag_errors + other_errors + assert_fails == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/fpu_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module fpu_assert (
	input wire logic clk,
	input wire logic rstn,
	input wire fpu_op_pkg::fpu_op_t op,
	input wire fp_format_pkg::fp_word_t y,
	input wire fpu_op_pkg::fpu_exc_t exc
);

	int fail_count = 0;	// summed into the closing line

	// ftoi reports either out of range or nan
	ovf_nan_exclusive: assert property (@(posedge clk) disable iff (!rstn)
		!(exc.ovf && exc.nan))
	else begin
		fail_count++;
		$error("ovf and nan set in the same result");
	end

	invalid_gives_zero: assert property (@(posedge clk) disable iff (!rstn)
		exc.invalid |-> (y == '0))
	else begin
		fail_count++;
		$error("result with invalid set has nonzero y");
	end

	// unused opcode 7 must reach the output flagged
	invalid_reaches_output: assert property (@(posedge clk) disable iff (!rstn)
		(3'(op) == 3'd7) |-> ##3 exc.invalid)
	else begin
		fail_count++;
		$error("unused opcode did not raise invalid three cycles later");
	end

endmodule

`default_nettype wire

/* rtl/fpu_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpu_config.svh"

module fpu_top (
	input wire logic clk,
	input wire logic rstn,
	input wire fpu_op_pkg::fpu_op_t op,
	input wire fp_format_pkg::fp_word_t a,
	input wire fp_format_pkg::fp_word_t b,
	output fp_format_pkg::fp_word_t y,
	output fpu_op_pkg::fpu_exc_t exc
);
	import fp_format_pkg::*;
	import fpu_op_pkg::*;

	fp_word_t sum, product, to_float, magnitude, negated;
	int_word_t to_int;
	logic add_ovf, mul_ovf, int_ovf, int_nan;
	logic subtract;
	fpu_op_t op_q;
	fpu_result_t sel_result, out_result;

	assign subtract = (op == OP_SUB);

	//////////////////////////////////////////////////////////////////////
	// arithmetic units, one register each
	fp_addsub u_addsub (.clk, .rstn, .a, .b, .subtract, .sum, .ovf(add_ovf));
	fp_mul u_mul (.clk, .rstn, .a, .b, .product, .ovf(mul_ovf));
	fp_convert u_convert (
		.clk, .rstn, .a,
		.b(int_word_t'(b)),	// itof reads b as an integer
		.to_int, .int_ovf, .int_nan, .to_float, .magnitude, .negated
	);

	// opcode follows the unit registers
	fpu_delay_line #(.payload_t(fpu_op_t), .depth(1)) u_op_delay (
		.clk, .rstn, .d(op), .q(op_q)
	);

	fpu_result_select u_select (
		.op(op_q), .sum, .product, .to_float, .magnitude, .negated, .to_int,
		.add_ovf, .mul_ovf, .int_ovf, .int_nan, .result(sel_result)
	);

	// remaining pipeline stages
	fpu_delay_line #(.payload_t(fpu_result_t), .depth(`FPU_LATENCY - 1)) u_out_delay (
		.clk, .rstn, .d(sel_result), .q(out_result)
	);

	assign y = out_result.value;
	assign exc = out_result.exc;

endmodule

`default_nettype wire

/* rtl/fpu_result_select.sv */
`timescale 1ns/100ps
`default_nettype none

module fpu_result_select (
	input wire fpu_op_pkg::fpu_op_t op,	// already aligned to unit outputs
	input wire fp_format_pkg::fp_word_t sum,
	input wire fp_format_pkg::fp_word_t product,
	input wire fp_format_pkg::fp_word_t to_float,
	input wire fp_format_pkg::fp_word_t magnitude,
	input wire fp_format_pkg::fp_word_t negated,
	input wire fp_format_pkg::int_word_t to_int,
	input wire logic add_ovf,
	input wire logic mul_ovf,
	input wire logic int_ovf,
	input wire logic int_nan,
	output fpu_op_pkg::fpu_result_t result
);
	import fpu_op_pkg::*;

	always_comb begin
		result = '0;
		case (op)
			OP_ADD, OP_SUB: begin
				result.value = sum;
				result.exc.ovf = add_ovf;
			end
			OP_MUL: begin
				result.value = product;
				result.exc.ovf = mul_ovf;
			end
			OP_FTOI: begin
				result.value = to_int;
				result.exc.ovf = int_ovf;
				result.exc.nan = int_nan;
			end
			OP_ITOF: result.value = to_float;
			OP_ABS: result.value = magnitude;
			OP_NEG: result.value = negated;
			default: result.exc.invalid = 1'b1;	// value stays zero
		endcase
	end

endmodule

`default_nettype wire

/* rtl/fpu_delay_line.sv */
`timescale 1ns/100ps
`default_nettype none

module fpu_delay_line #(
	parameter type payload_t = logic,
	parameter int depth = 1
) (
	input wire logic clk,
	input wire logic rstn,
	input wire payload_t d,
	output payload_t q
);

	payload_t stage [depth];

	always_ff @(posedge clk) begin
		if (!rstn) begin
			for (int i = 0; i < depth; i++)
				stage[i] <= payload_t'(0);
		end else begin
			stage[0] <= d;
			for (int i = 1; i < depth; i++)
				stage[i] <= stage[i-1];	// shift toward q
		end
	end

	assign q = stage[depth-1];

endmodule

`default_nettype wire

/* rtl/fp_convert.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpu_config.svh"

module fp_convert (
	input wire logic clk,
	input wire logic rstn,
	input wire fp_format_pkg::fp_word_t a,
	input wire fp_format_pkg::int_word_t b,
	output fp_format_pkg::int_word_t to_int,
	output logic int_ovf,
	output logic int_nan,
	output fp_format_pkg::fp_word_t to_float,
	output fp_format_pkg::fp_word_t magnitude,
	output fp_format_pkg::fp_word_t negated
);
	import fp_format_pkg::*;

	localparam int int_w = 32;
	localparam int sig_w = `FP_MAN_W + 1;
	localparam logic [`FP_EXP_W-1:0] exp_ones = `FP_EXP_MAX;

	fp_unpacked_t ua;
	logic [int_w+sig_w-1:0] fixed;	// binary point above bit 24
	logic [int_w:0] int_rnd;
	logic is_nan, ti_ovf;
	int_word_t ti_next;
	logic [int_w-1:0] mag, lifted;
	logic [4:0] lz;
	logic rnd_up;
	logic [sig_w:0] rounded;
	logic [`FP_EXP_W-1:0] exp_i;
	logic [`FP_MAN_W-1:0] man_i;
	fp_word_t tf_next;

	//////////////////////////////////////////////////////////////////////
	// float to int, half away from zero
	always_comb begin
		ua = fp_unpack(a);
		is_nan = (a.exp == exp_ones) && (|a.man);
		if (a.exp == `FP_BIAS - 1)
			fixed = {{int_w{1'b0}}, ua.sig};	// 0.5 up to 1
		else
			fixed = {{(int_w-1){1'b0}}, ua.sig, 1'b0} << (a.exp - `FP_BIAS);
		int_rnd = {1'b0, fixed[int_w+sig_w-1 -: int_w]} + {{int_w{1'b0}}, fixed[sig_w-1]};

		ti_next = '0;
		ti_ovf = 1'b0;
		if (is_nan || a.exp < `FP_BIAS - 1)
			ti_ovf = 1'b0;
		else if (a.exp > `FP_BIAS + int_w - 1)
			ti_ovf = 1'b1;
		else if (a.sign && int_rnd == {2'b01, {(int_w-1){1'b0}}})
			ti_next = {1'b1, {(int_w-1){1'b0}}};	// exactly -2^31
		else if (int_rnd[int_w] | int_rnd[int_w-1])
			ti_ovf = 1'b1;
		else
			ti_next = a.sign ? ~int_rnd[int_w-1:0] + 1'b1 : int_rnd[int_w-1:0];
	end

	//////////////////////////////////////////////////////////////////////
	// int to float, nearest even
	always_comb begin
		mag = b[int_w-1] ? ~b + 1'b1 : b;
		lz = '0;
		for (int i = 0; i < int_w; i++) begin
			if (mag[i])
				lz = 5'(int_w - 1 - i);
		end
		lifted = mag << lz;	// leading one at bit 31
		rnd_up = lifted[int_w-sig_w-1] & (lifted[int_w-sig_w] | (|lifted[int_w-sig_w-2:0]));
		rounded = {1'b0, lifted[int_w-1 -: sig_w]} + {{sig_w{1'b0}}, rnd_up};
		exp_i = `FP_EXP_W'(`FP_BIAS + int_w - 1) - `FP_EXP_W'(lz) + `FP_EXP_W'(rounded[sig_w]);
		man_i = rounded[sig_w] ? rounded[sig_w-1:1] : rounded[sig_w-2:0];
		tf_next = (b == 0) ? '0 : {b[int_w-1], exp_i, man_i};
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			to_int <= '0;
			int_ovf <= 1'b0;
			int_nan <= 1'b0;
			to_float <= '0;
			magnitude <= '0;
			negated <= '0;
		end else begin
			to_int <= ti_next;
			int_ovf <= ti_ovf;
			int_nan <= is_nan;
			to_float <= tf_next;
			magnitude <= {1'b0, a.exp, a.man};
			negated <= {~a.sign, a.exp, a.man};	// sign flip only, nan kept as is
		end
	end

endmodule

`default_nettype wire

/* rtl/fp_mul.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpu_config.svh"

module fp_mul (
	input wire logic clk,
	input wire logic rstn,
	input wire fp_format_pkg::fp_word_t a,
	input wire fp_format_pkg::fp_word_t b,
	output fp_format_pkg::fp_word_t product,
	output logic ovf
);
	import fp_format_pkg::*;

	localparam int sig_w = `FP_MAN_W + 1;
	localparam int prod_w = 2 * sig_w;
	localparam logic [`FP_EXP_W-1:0] exp_ones = `FP_EXP_MAX;

	fp_unpacked_t ua, ub;
	logic sy;
	logic [prod_w-1:0] prod, lifted, m48;
	logic [5:0] lz;
	logic signed [10:0] e_norm;	// biased, may go negative
	logic [10:0] rs_full, e1, e2;
	logic [5:0] rs;
	logic [2*prod_w-1:0] wide;
	logic subnormal, rnd_up, res_ovf;
	logic [sig_w:0] rounded;
	logic a_spec, b_spec, nan_a, nan_b, a_zero, b_zero;
	fp_word_t res, y_next;

	always_comb begin
		ua = fp_unpack(a);
		ub = fp_unpack(b);
		sy = a.sign ^ b.sign;
		prod = ua.sig * ub.sig;

		// leading one of the raw product, covers subnormal inputs too
		lz = 6'(prod_w);
		for (int i = 0; i < prod_w; i++) begin
			if (prod[i])
				lz = 6'(prod_w - 1 - i);
		end
		lifted = prod << lz;
		e_norm = 11'(ua.exp) + 11'(ub.exp) - 11'(`FP_BIAS - 1) - 11'(lz);

		//////////////////////////////////////////////////////////////////////
		// below normal range: shift right into a subnormal
		subnormal = e_norm < 1;
		rs_full = 11'(1) - e_norm;
		rs = (rs_full > 11'd50) ? 6'd50 : rs_full[5:0];
		wide = {lifted, {prod_w{1'b0}}} >> rs;
		m48 = subnormal ? {wide[2*prod_w-1 -: prod_w-1], |wide[prod_w:0]} : lifted;
		e1 = subnormal ? 11'd1 : e_norm;

		// nearest even on bit 24, guard at 23
		rnd_up = m48[prod_w-sig_w-1] & (m48[prod_w-sig_w] | (|m48[prod_w-sig_w-2:0]));
		rounded = {1'b0, m48[prod_w-1 -: sig_w]} + {{sig_w{1'b0}}, rnd_up};
		e2 = e1 + {10'b0, rounded[sig_w]};
		res_ovf = e2 >= `FP_EXP_MAX;

		res.sign = sy;
		res.exp = (rounded[sig_w] | rounded[sig_w-1]) ? e2[`FP_EXP_W-1:0] : '0;
		res.man = rounded[sig_w] ? rounded[sig_w-1:1] : rounded[sig_w-2:0];

		//////////////////////////////////////////////////////////////////////
		// special operands
		a_spec = a.exp == exp_ones;
		b_spec = b.exp == exp_ones;
		nan_a = a_spec & (|a.man);
		nan_b = b_spec & (|b.man);
		a_zero = {a.exp, a.man} == '0;
		b_zero = {b.exp, b.man} == '0;
		if (nan_a && !b_spec)
			y_next = {a.sign, exp_ones, 1'b1, a.man[`FP_MAN_W-2:0]};
		else if (nan_b && !a_spec)
			y_next = {b.sign, exp_ones, 1'b1, b.man[`FP_MAN_W-2:0]};
		else if ((a_spec && b_zero) || (a_zero && b_spec))
			y_next = {1'b1, exp_ones, 1'b1, {(`FP_MAN_W-1){1'b0}}};	// inf * 0
		else if (nan_b)
			y_next = {b.sign, exp_ones, 1'b1, b.man[`FP_MAN_W-2:0]};
		else if (nan_a)
			y_next = {a.sign, exp_ones, 1'b1, a.man[`FP_MAN_W-2:0]};
		else if (a_spec || b_spec || res_ovf)
			y_next = {sy, exp_ones, {`FP_MAN_W{1'b0}}};	// signed inf
		else
			y_next = res;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			product <= '0;
			ovf <= 1'b0;
		end else begin
			product <= y_next;
			ovf <= !a_spec && !b_spec && res_ovf;
		end
	end

endmodule

`default_nettype wire

/* rtl/fp_addsub.sv */
`timescale 1ns/100ps
`default_nettype none
`include "fpu_config.svh"

module fp_addsub (
	input wire logic clk,
	input wire logic rstn,
	input wire fp_format_pkg::fp_word_t a,
	input wire fp_format_pkg::fp_word_t b,
	input wire logic subtract,	// 1 gives a - b
	output fp_format_pkg::fp_word_t sum,
	output logic ovf
);
	import fp_format_pkg::*;

	localparam int sig_w = `FP_MAN_W + 1;
	localparam int ext_w = sig_w + `FP_GRS_W;
	localparam logic [`FP_EXP_W-1:0] exp_ones = `FP_EXP_MAX;

	fp_unpacked_t ua, ub, uw, ul;	// w is the larger magnitude
	logic sb, eff_sub, a_ge, a_eq;
	logic [`FP_EXP_W-1:0] eshift;
	logic [5:0] sh;
	logic [sig_w+ext_w-1:0] wide;
	logic [ext_w-1:0] aligned, norm;
	logic [ext_w:0] raw;	// carry + significand + grs
	logic [4:0] lz;
	logic [`FP_EXP_W:0] exp1, exp2;
	logic rnd_up, res_sign, res_ovf;
	logic [sig_w:0] rounded;
	logic a_spec, b_spec, nan_a, nan_b;
	fp_word_t res, y_next;

	always_comb begin
		ua = fp_unpack(a);
		ub = fp_unpack(b);
		sb = b.sign ^ subtract;
		eff_sub = a.sign ^ sb;
		a_ge = {a.exp, a.man} >= {b.exp, b.man};
		a_eq = {a.exp, a.man} == {b.exp, b.man};
		uw = a_ge ? ua : ub;
		ul = a_ge ? ub : ua;

		//////////////////////////////////////////////////////////////////////
		// alignment of the smaller operand
		eshift = uw.exp - ul.exp;
		sh = (eshift > `FP_EXP_W'(ext_w)) ? 6'(ext_w) : eshift[5:0];
		wide = {ul.sig, {ext_w{1'b0}}} >> sh;
		aligned = {wide[sig_w+ext_w-1 -: ext_w-1], |wide[sig_w:0]};	// fold sticky

		if (eff_sub)
			raw = {1'b0, uw.sig, {`FP_GRS_W{1'b0}}} - {1'b0, aligned};
		else
			raw = {1'b0, uw.sig, {`FP_GRS_W{1'b0}}} + {1'b0, aligned};

		// leading zeros below the carry bit
		lz = 5'(ext_w);
		for (int i = 0; i < ext_w; i++) begin
			if (raw[i])
				lz = 5'(ext_w - 1 - i);
		end

		//////////////////////////////////////////////////////////////////////
		// normalize, never below exponent 1
		if (raw[ext_w]) begin
			norm = {raw[ext_w:2], |raw[1:0]};
			exp1 = {1'b0, uw.exp} + 1'b1;
		end else if ({3'b0, lz} < uw.exp) begin
			norm = raw[ext_w-1:0] << lz;
			exp1 = {1'b0, uw.exp} - {4'b0, lz};
		end else begin
			norm = raw[ext_w-1:0] << (uw.exp - 1'b1);	// ends up subnormal
			exp1 = `FP_EXP_W'(1);
		end

		// round to nearest even
		rnd_up = norm[`FP_GRS_W-1] & (norm[`FP_GRS_W] | (|norm[`FP_GRS_W-2:0]));
		rounded = {1'b0, norm[ext_w-1:`FP_GRS_W]} + {{sig_w{1'b0}}, rnd_up};
		exp2 = exp1 + {{`FP_EXP_W{1'b0}}, rounded[sig_w]};
		res_ovf = exp2 >= `FP_EXP_MAX;

		// equal magnitudes cancel to +0
		res_sign = !eff_sub ? a.sign : a_eq ? 1'b0 : a_ge ? a.sign : sb;
		res.sign = res_sign;
		res.exp = (rounded[sig_w] | rounded[sig_w-1]) ? exp2[`FP_EXP_W-1:0] : '0;
		res.man = rounded[sig_w] ? rounded[sig_w-1:1] : rounded[sig_w-2:0];
		if (res_ovf) begin
			res.exp = exp_ones;
			res.man = '0;
		end

		//////////////////////////////////////////////////////////////////////
		// inf and nan
		a_spec = a.exp == exp_ones;
		b_spec = b.exp == exp_ones;
		nan_a = a_spec & (|a.man);
		nan_b = b_spec & (|b.man);
		if (a_spec && !b_spec)
			y_next = {a.sign, exp_ones, nan_a, a.man[`FP_MAN_W-2:0]};
		else if (!a_spec && b_spec)
			y_next = {sb, exp_ones, nan_b, b.man[`FP_MAN_W-2:0]};
		else if (nan_b)
			y_next = {b.sign, exp_ones, 1'b1, b.man[`FP_MAN_W-2:0]};
		else if (nan_a)
			y_next = {a.sign, exp_ones, 1'b1, a.man[`FP_MAN_W-2:0]};
		else if (a_spec && !eff_sub)
			y_next = {a.sign, exp_ones, {`FP_MAN_W{1'b0}}};
		else if (a_spec)
			y_next = {1'b1, exp_ones, 1'b1, {(`FP_MAN_W-1){1'b0}}};	// inf - inf
		else
			y_next = res;
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			sum <= '0;
			ovf <= 1'b0;
		end else begin
			sum <= y_next;
			ovf <= !a_spec && !b_spec && res_ovf;
		end
	end

endmodule

`default_nettype wire

/* rtl/fpu_op_pkg.sv */
`default_nettype none
`include "fpu_config.svh"

package fpu_op_pkg;

	// code 3'd7 is left unused and reports invalid
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_MUL  = 3'd2,
		OP_ABS  = 3'd3,
		OP_NEG  = 3'd4,
		OP_FTOI = 3'd5,
		OP_ITOF = 3'd6
	} fpu_op_t;

	typedef struct packed {
		logic ovf;
		logic nan;	// ftoi of a nan
		logic invalid;	// unused opcode
	} fpu_exc_t;

	typedef struct packed {
		logic [`FP_EXP_W+`FP_MAN_W:0] value;
		fpu_exc_t exc;
	} fpu_result_t;

endpackage

`default_nettype wire

/* rtl/fp_format_pkg.sv */
`default_nettype none
`include "fpu_config.svh"

package fp_format_pkg;

	// ieee-754 single-precision word
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;
		logic [`FP_MAN_W-1:0] man;
	} fp_word_t;

	// operand with hidden bit made explicit
	typedef struct packed {
		logic sign;
		logic [`FP_EXP_W-1:0] exp;	// 1 for subnormals
		logic [`FP_MAN_W:0] sig;	// hidden bit on top
	} fp_unpacked_t;

	typedef logic signed [31:0] int_word_t;

	function automatic fp_unpacked_t fp_unpack(input fp_word_t w);
		fp_unpacked_t u;
		u.sign = w.sign;
		u.exp = (w.exp == '0) ? `FP_EXP_W'(1) : w.exp;	// true exponent of a subnormal is -126
		u.sig = {(w.exp != '0), w.man};
		return u;
	endfunction

endpackage

`default_nettype wire

/* rtl/fpu_config.svh */
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// single-precision field widths
`define FP_EXP_W 8
`define FP_MAN_W 23

// exponent bias and the all-ones code used by inf and nan
`define FP_BIAS 127
`define FP_EXP_MAX 255

// guard, round and sticky bits carried into rounding
`define FP_GRS_W 3

// edges from issue to result at the top level
`define FPU_LATENCY 3

`endif
